//--- rtl/rv_pkg.sv
// RV32I subset types and encodings; CSR_LED_ADDR is the only CSR that is implemented
`default_nettype none

package rv_pkg;

  typedef logic [31:0] word;
  typedef logic [4:0] reg_idx;

  // one instruction word seen through each base format
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [11:0] imm11_0;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i;
    struct packed {
      logic [6:0] imm11_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm4_0;
      logic [6:0] opcode;
    } s;
    struct packed {
      logic       imm12;
      logic [5:0] imm10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm4_1;
      logic       imm11;
      logic [6:0] opcode;
    } b;
    struct packed {
      logic [19:0] imm31_12;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } u;
  } instr_t;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_COPY_B
  } alu_op_t;

  typedef enum logic [1:0] {A_RS1, A_PC, A_ZERO} a_sel_t;
  typedef enum logic {B_RS2, B_IMM} b_sel_t;
  typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_CSR, WB_PC4} wb_sel_t;
  // matches funct3[1:0] of loads and stores
  typedef enum logic [1:0] {MEM_BYTE, MEM_HALF, MEM_WORD} mem_width_t;
  typedef enum logic [1:0] {CSR_WRITE, CSR_SET, CSR_CLEAR} csr_op_t;

  typedef struct packed {
    a_sel_t     a_sel;
    b_sel_t     b_sel;
    alu_op_t    alu_op;
    logic       branch;
    logic       jump;
    wb_sel_t    wb_sel;
    logic       wb_en;
    logic       mem_write;
    mem_width_t mem_width;
    logic       mem_signed;
    logic       csr_en;
    csr_op_t    csr_op;
    logic       csr_imm;
  } ctrl_t;

  localparam int DMEM_WORDS = 256;
  localparam int IMEM_WORDS = 64;
  localparam logic [11:0] CSR_LED_ADDR = 12'h7c0;
  // addi x0, x0, 0
  localparam word NOP_INSTR = 32'h0000_0013;

  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  localparam logic [2:0] F3_LB  = 3'b000;
  localparam logic [2:0] F3_LH  = 3'b001;
  localparam logic [2:0] F3_LW  = 3'b010;
  localparam logic [2:0] F3_LBU = 3'b100;
  localparam logic [2:0] F3_LHU = 3'b101;

  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

endpackage

`default_nettype wire

//--- rtl/instr_rom.sv
// asynchronous read, program loaded once at time zero; words past DEPTH read as a nop
`default_nettype none
`timescale 1ns/10ps

module instr_rom #(
  parameter string IMEM_FILE = "dv/prog.hex",
  parameter int    DEPTH     = rv_pkg::IMEM_WORDS
) (
  input  wire            clk,
  input  wire rv_pkg::word addr,
  output rv_pkg::instr_t instr
);
  import rv_pkg::*;

  word rom [DEPTH];

  initial begin
    $readmemh(IMEM_FILE, rom);
  end

  // word address, no fetch latency
  always_comb begin
    if (addr < DEPTH) begin
      instr = rom[addr[$clog2(DEPTH)-1:0]];
    end else begin
      instr = NOP_INSTR;
    end
  end

endmodule

`default_nettype wire

//--- rtl/decoder.sv
// decodes the supported RV32I subset only; anything else becomes a nop with all enables off
`default_nettype none
`timescale 1ns/10ps

module decoder (
  input  wire rv_pkg::instr_t instr,
  output rv_pkg::reg_idx      rs1,
  output rv_pkg::reg_idx      rs2,
  output rv_pkg::reg_idx      rd,
  output rv_pkg::word         imm,
  output rv_pkg::ctrl_t       ctrl
);
  import rv_pkg::*;

  word imm_i;
  word imm_s;
  word imm_b;
  word imm_u;
  word imm_j;
  logic [2:0] f3;

  function automatic alu_op_t alu_decode(logic [2:0] funct3, logic alt, logic is_reg);
    case (funct3)
      F3_ADD_SUB: return (is_reg && alt) ? ALU_SUB : ALU_ADD;
      F3_SLL:     return ALU_SLL;
      F3_SLT:     return ALU_SLT;
      F3_SLTU:    return ALU_SLTU;
      F3_XOR:     return ALU_XOR;
      F3_SRL_SRA: return alt ? ALU_SRA : ALU_SRL;
      F3_OR:      return ALU_OR;
      default:    return ALU_AND;
    endcase
  endfunction

  assign rs1 = instr.r.rs1;
  assign rs2 = instr.r.rs2;
  assign rd  = instr.r.rd;
  assign f3  = instr.r.funct3;

  // immediates through the format views
  assign imm_i = {{20{instr.i.imm11_0[11]}}, instr.i.imm11_0};
  assign imm_s = {{20{instr.s.imm11_5[6]}}, instr.s.imm11_5, instr.s.imm4_0};
  assign imm_b = {{20{instr.b.imm12}}, instr.b.imm11, instr.b.imm10_5, instr.b.imm4_1, 1'b0};
  assign imm_u = {instr.u.imm31_12, 12'b0};
  // J bits are scattered across the U field
  assign imm_j = {{12{instr.u.imm31_12[19]}}, instr.u.imm31_12[7:0], instr.u.imm31_12[8],
                  instr.u.imm31_12[18:9], 1'b0};

  always_comb begin
    ctrl = '0;
    imm  = imm_i;
    case (instr.r.opcode)
      OPC_LUI: begin
        imm = imm_u;
        ctrl.a_sel  = A_ZERO;
        ctrl.b_sel  = B_IMM;
        ctrl.alu_op = ALU_COPY_B;
        ctrl.wb_en  = 1'b1;
      end
      OPC_AUIPC: begin
        imm = imm_u;
        ctrl.a_sel = A_PC;
        ctrl.b_sel = B_IMM;
        ctrl.wb_en = 1'b1;
      end
      OPC_JAL: begin
        imm = imm_j;
        ctrl.a_sel  = A_PC;
        ctrl.b_sel  = B_IMM;
        ctrl.jump   = 1'b1;
        ctrl.wb_sel = WB_PC4;
        ctrl.wb_en  = 1'b1;
      end
      OPC_JALR: begin
        ctrl.b_sel  = B_IMM;
        ctrl.jump   = 1'b1;
        ctrl.wb_sel = WB_PC4;
        ctrl.wb_en  = 1'b1;
      end
      OPC_BRANCH: begin
        imm = imm_b;
        ctrl.branch = 1'b1;
      end
      OPC_LOAD: begin
        ctrl.b_sel  = B_IMM;
        ctrl.wb_sel = WB_MEM;
        ctrl.wb_en  = 1'b1;
        case (f3)
          F3_LB:  ctrl.mem_width = MEM_BYTE;
          F3_LH:  ctrl.mem_width = MEM_HALF;
          F3_LW:  ctrl.mem_width = MEM_WORD;
          F3_LBU: ctrl.mem_width = MEM_BYTE;
          F3_LHU: ctrl.mem_width = MEM_HALF;
          default: ctrl.wb_en = 1'b0;
        endcase
        ctrl.mem_signed = (f3 == F3_LB) || (f3 == F3_LH);
      end
      OPC_STORE: begin
        imm = imm_s;
        ctrl.b_sel     = B_IMM;
        ctrl.mem_write = 1'b1;
        ctrl.mem_width = mem_width_t'(f3[1:0]);
      end
      OPC_OP_IMM: begin
        ctrl.b_sel  = B_IMM;
        ctrl.alu_op = alu_decode(f3, instr.r.funct7[5], 1'b0);
        ctrl.wb_en  = 1'b1;
      end
      OPC_OP: begin
        ctrl.alu_op = alu_decode(f3, instr.r.funct7[5], 1'b1);
        ctrl.wb_en  = 1'b1;
      end
      OPC_SYSTEM: begin
        // csr address sits in imm[11:0]
        ctrl.wb_sel  = WB_CSR;
        ctrl.csr_imm = f3[2];
        ctrl.csr_en  = (f3[1:0] != 2'b00);
        ctrl.wb_en   = (f3[1:0] != 2'b00);
        case (f3[1:0])
          2'b10:   ctrl.csr_op = CSR_SET;
          2'b11:   ctrl.csr_op = CSR_CLEAR;
          default: ctrl.csr_op = CSR_WRITE;
        endcase
      end
      default: ctrl = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- rtl/register_file.sv
// 32 registers cleared by reset, reads are combinational so a write shows up next cycle
`default_nettype none
`timescale 1ns/10ps

module register_file (
  input  wire                 clk,
  input  wire                 reset,
  input  wire                 we,
  input  wire rv_pkg::reg_idx waddr,
  input  wire rv_pkg::reg_idx raddr1,
  input  wire rv_pkg::reg_idx raddr2,
  input  wire rv_pkg::word    wdata,
  output rv_pkg::word         rdata1,
  output rv_pkg::word         rdata2
);
  import rv_pkg::*;

  word regs [32];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int k = 0; k < 32; k++) begin
        regs[k] <= '0;
      end
    end else if (we && (waddr != '0)) begin
      // x0 is never written so it stays zero
      regs[waddr] <= wdata;
    end
  end

  assign rdata1 = regs[raddr1];
  assign rdata2 = regs[raddr2];

endmodule

`default_nettype wire

//--- rtl/alu.sv
// purely combinational, shifts use the low five bits of operand b
`default_nettype none
`timescale 1ns/10ps

module alu (
  input  wire rv_pkg::word   rs1_data,
  input  wire rv_pkg::word   rs2_data,
  input  wire rv_pkg::word   pc,
  input  wire rv_pkg::word   imm,
  input  wire rv_pkg::ctrl_t ctrl,
  output rv_pkg::word        res
);
  import rv_pkg::*;

  word a;
  word b;
  logic [4:0] shamt;

  always_comb begin
    case (ctrl.a_sel)
      A_PC:    a = pc;
      A_ZERO:  a = '0;
      default: a = rs1_data;
    endcase
    b = (ctrl.b_sel == B_IMM) ? imm : rs2_data;
  end

  assign shamt = b[4:0];

  always_comb begin
    case (ctrl.alu_op)
      ALU_ADD:    res = a + b;
      ALU_SUB:    res = a - b;
      ALU_SLL:    res = a << shamt;
      ALU_SLT:    res = {31'b0, $signed(a) < $signed(b)};
      ALU_SLTU:   res = {31'b0, a < b};
      ALU_XOR:    res = a ^ b;
      ALU_SRL:    res = a >> shamt;
      ALU_SRA:    res = word'($signed(a) >>> shamt);
      ALU_OR:     res = a | b;
      ALU_AND:    res = a & b;
      default:    res = b;
    endcase
  end

endmodule

`default_nettype wire

//--- rtl/branch_logic.sv
// conditional branches only; jumps are resolved in the commit unit
`default_nettype none
`timescale 1ns/10ps

module branch_logic (
  input  wire rv_pkg::word   rs1_data,
  input  wire rv_pkg::word   rs2_data,
  input  wire [2:0]          funct3,
  input  wire rv_pkg::ctrl_t ctrl,
  output logic               taken
);
  import rv_pkg::*;

  logic cond;

  always_comb begin
    case (funct3)
      F3_BEQ:  cond = (rs1_data == rs2_data);
      F3_BNE:  cond = (rs1_data != rs2_data);
      F3_BLT:  cond = ($signed(rs1_data) < $signed(rs2_data));
      F3_BGE:  cond = ($signed(rs1_data) >= $signed(rs2_data));
      F3_BLTU: cond = (rs1_data < rs2_data);
      F3_BGEU: cond = (rs1_data >= rs2_data);
      // 010 and 011 are not branches
      default: cond = 1'b0;
    endcase
  end

  assign taken = ctrl.branch && cond;

endmodule

`default_nettype wire

//--- rtl/commit_unit.sv
// next pc and writeback select; jalr is told from jal by the rs1 operand select
`default_nettype none
`timescale 1ns/10ps

module commit_unit (
  input  wire rv_pkg::word   pc,
  input  wire rv_pkg::word   imm,
  input  wire rv_pkg::word   alu_res,
  input  wire rv_pkg::word   mem_data,
  input  wire rv_pkg::word   csr_old,
  input  wire                taken,
  input  wire rv_pkg::ctrl_t ctrl,
  output rv_pkg::word        next_pc,
  output rv_pkg::word        wb_data
);
  import rv_pkg::*;

  word pc_plus4;
  word pc_target;

  assign pc_plus4  = pc + 32'd4;
  assign pc_target = pc + imm;

  always_comb begin
    if (ctrl.jump && (ctrl.a_sel == A_RS1)) begin
      // jalr target with bit 0 dropped
      next_pc = {alu_res[31:1], 1'b0};
    end else if (ctrl.jump || taken) begin
      next_pc = pc_target;
    end else begin
      next_pc = pc_plus4;
    end
  end

  always_comb begin
    case (ctrl.wb_sel)
      WB_MEM:  wb_data = mem_data;
      WB_CSR:  wb_data = csr_old;
      WB_PC4:  wb_data = pc_plus4;
      default: wb_data = alu_res;
    endcase
  end

endmodule

`default_nettype wire

//--- rtl/data_mem.sv
// not cleared by reset; misaligned accesses are forced down to the access alignment
`default_nettype none
`timescale 1ns/10ps

module data_mem #(
  parameter int DEPTH = rv_pkg::DMEM_WORDS
) (
  input  wire                clk,
  input  wire rv_pkg::word   addr,
  input  wire rv_pkg::word   wdata,
  input  wire rv_pkg::ctrl_t ctrl,
  output rv_pkg::word        rdata
);
  import rv_pkg::*;

  localparam int AW = $clog2(DEPTH);

  word mem [DEPTH];
  logic [AW-1:0] widx;
  logic [1:0] off;
  logic [3:0] be;
  word wlanes;
  word rword;
  logic [7:0] rbyte;
  logic [15:0] rhalf;

  assign widx = addr[AW+1:2];

  // byte offset, lane enables and replicated store data
  always_comb begin
    case (ctrl.mem_width)
      MEM_BYTE: begin
        off    = addr[1:0];
        wlanes = {4{wdata[7:0]}};
      end
      MEM_HALF: begin
        off    = {addr[1], 1'b0};
        wlanes = {2{wdata[15:0]}};
      end
      default: begin
        off    = 2'b00;
        wlanes = wdata;
      end
    endcase
    case (ctrl.mem_width)
      MEM_BYTE: be = 4'b0001 << off;
      MEM_HALF: be = 4'b0011 << off;
      default:  be = 4'b1111;
    endcase
  end

  assign rword = mem[widx];
  assign rbyte = rword[{off, 3'b000} +: 8];
  assign rhalf = rword[{off, 3'b000} +: 16];

  always_comb begin
    case (ctrl.mem_width)
      MEM_BYTE: rdata = {{24{ctrl.mem_signed & rbyte[7]}}, rbyte};
      MEM_HALF: rdata = {{16{ctrl.mem_signed & rhalf[15]}}, rhalf};
      default:  rdata = rword;
    endcase
  end

  always_ff @(posedge clk) begin
    if (ctrl.mem_write) begin
      for (int k = 0; k < 4; k++) begin
        if (be[k]) begin
          mem[widx][8*k +: 8] <= wlanes[8*k +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/csr_led.sv
// only the led CSR exists; reads of any other CSR address return zero and writes are dropped
`default_nettype none
`timescale 1ns/10ps

module csr_led (
  input  wire                 clk,
  input  wire                 reset,
  input  wire [11:0]          addr,
  input  wire rv_pkg::word    rs1_data,
  input  wire rv_pkg::reg_idx zimm,
  input  wire rv_pkg::ctrl_t  ctrl,
  output rv_pkg::word         old_value,
  output rv_pkg::word         led
);
  import rv_pkg::*;

  word led_q;
  word operand;
  logic hit;

  assign hit     = (addr == CSR_LED_ADDR);
  assign operand = ctrl.csr_imm ? {27'b0, zimm} : rs1_data;

  // value before this cycle's update
  assign old_value = hit ? led_q : '0;

  always_ff @(posedge clk) begin
    if (reset) begin
      led_q <= '0;
    end else if (ctrl.csr_en && hit) begin
      case (ctrl.csr_op)
        CSR_SET:   led_q <= led_q | operand;
        CSR_CLEAR: led_q <= led_q & ~operand;
        default:   led_q <= operand;
      endcase
    end
  end

  assign led = led_q;

endmodule

`default_nettype wire

//--- rtl/top.sv
// single-cycle core, one instruction per clock with no stalls; program comes from dv/prog.hex
`default_nettype none
`timescale 1ns/10ps

module top (
  input  wire         clk,
  input  wire         reset,
  output rv_pkg::word led
);
  import rv_pkg::*;

  word pc_q;
  word next_pc;
  instr_t instr;
  reg_idx rs1;
  reg_idx rs2;
  reg_idx rd;
  word imm;
  ctrl_t ctrl;
  word rs1_data;
  word rs2_data;
  word alu_res;
  logic taken;
  word mem_rdata;
  word csr_old;
  word wb_data;

  // pc register
  always_ff @(posedge clk) begin
    if (reset) begin
      pc_q <= '0;
    end else begin
      pc_q <= next_pc;
    end
  end

  instr_rom instr_rom (
    .clk(clk),
    .addr({2'b00, pc_q[31:2]}),
    .instr(instr)
  );

  decoder decoder (
    .instr(instr),
    .rs1(rs1),
    .rs2(rs2),
    .rd(rd),
    .imm(imm),
    .ctrl(ctrl)
  );

  register_file rf (
    .clk(clk),
    .reset(reset),
    .we(ctrl.wb_en),
    .waddr(rd),
    .raddr1(rs1),
    .raddr2(rs2),
    .wdata(wb_data),
    .rdata1(rs1_data),
    .rdata2(rs2_data)
  );

  // alu and comparator work side by side
  alu alu (
    .rs1_data(rs1_data),
    .rs2_data(rs2_data),
    .pc(pc_q),
    .imm(imm),
    .ctrl(ctrl),
    .res(alu_res)
  );

  branch_logic branch_logic (
    .rs1_data(rs1_data),
    .rs2_data(rs2_data),
    .funct3(instr.b.funct3),
    .ctrl(ctrl),
    .taken(taken)
  );

  data_mem dmem (
    .clk(clk),
    .addr(alu_res),
    .wdata(rs2_data),
    .ctrl(ctrl),
    .rdata(mem_rdata)
  );

  // csr address from imm[11:0], rs1 index doubles as zimm
  csr_led csr (
    .clk(clk),
    .reset(reset),
    .addr(imm[11:0]),
    .rs1_data(rs1_data),
    .zimm(rs1),
    .ctrl(ctrl),
    .old_value(csr_old),
    .led(led)
  );

  commit_unit commit_unit (
    .pc(pc_q),
    .imm(imm),
    .alu_res(alu_res),
    .mem_data(mem_rdata),
    .csr_old(csr_old),
    .taken(taken),
    .ctrl(ctrl),
    .next_pc(next_pc),
    .wb_data(wb_data)
  );

endmodule

`default_nettype wire

//--- dv/tb_top.sv
// runs dv/prog.hex on the core and checks each new led value in order; assertions must be enabled
`timescale 1ns/10ps
`default_nettype none

module tb_top;
  import rv_pkg::*;

  localparam int  CLK_PERIOD     = 4;
  localparam int  RESET_CYCLES   = 10;
  localparam int  LOOP_FACTOR    = 8;
  // every rom word a few times over, plus reset
  localparam int  TIMEOUT_CYCLES = IMEM_WORDS * LOOP_FACTOR + RESET_CYCLES;
  localparam int  NUM_EXP        = 8;
  localparam word END_MARKER     = 32'h600d_0000;

  logic clk;
  logic reset;
  word  led;

  word  exp_led [NUM_EXP];
  word  last_led;
  int   exp_idx;
  int   errors;
  logic end_seen;

  top uut (
    .clk(clk),
    .reset(reset),
    .led(led)
  );

  function automatic string check_name(int idx);
    case (idx)
      0: return "arith";
      1: return "load_store";
      2: return "branch_jump";
      3: return "csrrw";
      4: return "csrrs";
      5: return "csrrci";
      6: return "csr_readback";
      default: return "end_marker";
    endcase
  endfunction

  task automatic print_counts();
    $display("errors: %0d, led values seen: %0d of %0d", errors, exp_idx, NUM_EXP);
  endtask

  initial begin
    clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clk = ~clk;
    end
  end

  initial begin
    reset    = 1'b1;
    errors   = 0;
    exp_idx  = 0;
    last_led = '0;
    end_seen = 1'b0;

    // -20 - 7 = -27, then sra by 2 gives -7; sltu(7, 0xfffffff9) adds 1
    exp_led[0] = word'(((-32'sd20 - 32'sd7) >>> 2) + 32'sd1);
    // word 0x807ffe81 at byte 16, bytes 81 fe 7f 80 and halves fe81 807f
    // lb, lbu, lh and lhu summed in that order
    exp_led[1] = word'(-127 - 2 + 127 - 128
                       + 129 + 254 + 127 + 128
                       - 383 - 32641
                       + 65153 + 32895);
    // loop runs 5 times, both poison adds skipped, the called routine adds 0x30
    // link register holds the jal address 0xb0 plus 4
    exp_led[2] = ((32'd5 + 32'h30) << 8) + 32'hb4;
    // csrrw with 0xf0
    exp_led[3] = 32'h0000_00f0;
    // csrrs ORs in 0x30f
    exp_led[4] = 32'h0000_00f0 | 32'h0000_030f;
    // csrrci clears the zimm bits 5
    exp_led[5] = exp_led[4] & ~32'd5;
    // sum of the three old values read back
    exp_led[6] = exp_led[2] + exp_led[3] + exp_led[4];
    exp_led[7] = END_MARKER;

    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    assert (led === '0) else begin
      errors++;
      $display("mismatch after_reset: expected %h, actual %h", 32'h0, led);
    end

    wait (end_seen);
    // catch any stray write after the marker
    repeat (8) @(negedge clk);
    assert (exp_idx == NUM_EXP) else begin
      errors++;
      $display("only %0d of %0d expected led values were seen", exp_idx, NUM_EXP);
    end
    print_counts();
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // each new led value against the next expected entry
  always @(negedge clk) begin
    if (!reset && (led !== last_led)) begin
      assert (exp_idx < NUM_EXP) else begin
        errors++;
        $display("led changed to %h after the last expected value", led);
      end
      if (exp_idx < NUM_EXP) begin
        assert (led === exp_led[exp_idx]) else begin
          errors++;
          $display("mismatch %s: expected %h, actual %h", check_name(exp_idx),
                   exp_led[exp_idx], led);
        end
        exp_idx++;
      end
      if (led === END_MARKER) begin
        end_seen = 1'b1;
      end
      last_led = led;
    end
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("timeout: the program did not write the end marker within %0d cycles",
             TIMEOUT_CYCLES);
    print_counts();
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- dv/prog.hex
// one instruction word per line in hex; the comment gives its byte address and assembly
// led CSR is 0x7c0, data word at byte 16, end marker 0x600d0000
fec00093 // 00 addi x1, x0, -20
00700113 // 04 addi x2, x0, 7
402081b3 // 08 sub x3, x1, x2
00200213 // 0c addi x4, x0, 2
4041d2b3 // 10 sra x5, x3, x4
00513333 // 14 sltu x6, x2, x5
006283b3 // 18 add x7, x5, x6
7c039073 // 1c csrrw x0, led, x7
80800437 // 20 lui x8, 0x80800
e8140413 // 24 addi x8, x8, -383
00802823 // 28 sw x8, 16(x0)
01000483 // 2c lb x9, 16(x0)
01100503 // 30 lb x10, 17(x0)
00a484b3 // 34 add x9, x9, x10
01200503 // 38 lb x10, 18(x0)
00a484b3 // 3c add x9, x9, x10
01300503 // 40 lb x10, 19(x0)
00a484b3 // 44 add x9, x9, x10
01004503 // 48 lbu x10, 16(x0)
00a484b3 // 4c add x9, x9, x10
01104503 // 50 lbu x10, 17(x0)
00a484b3 // 54 add x9, x9, x10
01204503 // 58 lbu x10, 18(x0)
00a484b3 // 5c add x9, x9, x10
01304503 // 60 lbu x10, 19(x0)
00a484b3 // 64 add x9, x9, x10
01001503 // 68 lh x10, 16(x0)
00a484b3 // 6c add x9, x9, x10
01201503 // 70 lh x10, 18(x0)
00a484b3 // 74 add x9, x9, x10
01005503 // 78 lhu x10, 16(x0)
00a484b3 // 7c add x9, x9, x10
01205503 // 80 lhu x10, 18(x0)
00a484b3 // 84 add x9, x9, x10
7c049073 // 88 csrrw x0, led, x9
00500513 // 8c addi x10, x0, 5
00000593 // 90 addi x11, x0, 0
00158593 // 94 addi x11, x11, 1
fff50513 // 98 addi x10, x10, -1
fe051ce3 // 9c bne x10, x0, 0x94
0020c463 // a0 blt x1, x2, 0xa8
04058593 // a4 addi x11, x11, 64
0020f463 // a8 bgeu x1, x2, 0xb0
04058593 // ac addi x11, x11, 64
0140066f // b0 jal x12, 0xc4
00859693 // b4 slli x13, x11, 8
00c686b3 // b8 add x13, x13, x12
7c069073 // bc csrrw x0, led, x13
00c0006f // c0 jal x0, 0xcc
03058593 // c4 addi x11, x11, 0x30
00060067 // c8 jalr x0, 0(x12)
0f000713 // cc addi x14, x0, 0xf0
7c0717f3 // d0 csrrw x15, led, x14
30f00713 // d4 addi x14, x0, 0x30f
7c072873 // d8 csrrs x16, led, x14
7c02f8f3 // dc csrrci x17, led, 5
01078933 // e0 add x18, x15, x16
01190933 // e4 add x18, x18, x17
7c091073 // e8 csrrw x0, led, x18
600d09b7 // ec lui x19, 0x600d0
7c099073 // f0 csrrw x0, led, x19
0000006f // f4 jal x0, 0xf4

//--- tb.f
rtl/rv_pkg.sv
rtl/instr_rom.sv
rtl/decoder.sv
rtl/register_file.sv
rtl/alu.sv
rtl/branch_logic.sv
rtl/commit_unit.sv
rtl/data_mem.sv
rtl/csr_led.sv
rtl/top.sv
dv/tb_top.sv

//--- Makefile
TOP = tb_top

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f tb.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^TEST OK$$" sim.log

clean:
	rm -rf obj_dir sim.log
